// ==== access_decode.sv ====
// decode of one core access into masked word accesses
// works out the byte lanes touched in the first and the next word
// and places store data on those lanes, purely combinational
`timescale 1ns/10ps

module access_decode (
   input  mem_pkg::mem_req_t     i_req,
   output mem_pkg::access_plan_t o_plan
);
   import mem_pkg::*;

   logic [1:0]  offset;
   logic [1:0]  size;
   logic [3:0]  base_mask;   // lanes as if aligned
   logic [31:0] base_data;
   logic [7:0]  lane_mask;   // low nibble first word, high nibble next word
   logic [63:0] lane_data;

   assign offset = i_req.addr[1:0];
   assign size   = i_req.ctrl[1:0];

   // size to aligned mask and trimmed data
   always_comb begin
      case (size)
         SZ_BYTE: begin
            base_mask = 4'b0001;
            base_data = {24'h0, i_req.wdata[7:0]};
         end
         SZ_HALF: begin
            base_mask = 4'b0011;
            base_data = {16'h0, i_req.wdata[15:0]};
         end
         default: begin  // word
            base_mask = 4'b1111;
            base_data = i_req.wdata;
         end
      endcase
   end

   // move mask and data up by the byte offset
   // anything pushed past byte 3 lands in the next word
   assign lane_mask = {4'b0000, base_mask} << offset;
   assign lane_data = {32'h0, base_data} << {offset, 3'b000};

   always_comb begin
      o_plan.two    = |lane_mask[7:4];
      o_plan.mask0  = lane_mask[3:0];
      o_plan.mask1  = lane_mask[7:4];
      o_plan.wdata0 = lane_data[31:0];
      o_plan.wdata1 = lane_data[63:32];   // spill-over shifted down
      o_plan.offset = offset;
      o_plan.ctrl   = i_req.ctrl;
   end

endmodule

// ==== access_sequencer.sv ====
// execute block of the load/store unit
// accepts a request while idle, then runs one or two word accesses
// against the memory busy handshake and captures read words
// o_busy is the local stall or'd with memory busy
`timescale 1ns/10ps

module access_sequencer (
   input  logic                  clk,
   input  logic                  rst_x,
   input  logic                  i_rd_en,
   input  logic                  i_wr_en,
   input  mem_pkg::access_plan_t i_plan,
   input  logic [29:0]           i_word_addr,
   input  logic                  i_mem_busy,
   input  logic [31:0]           i_mem_rdata,
   output mem_pkg::mem_port_t    o_mem,
   output mem_pkg::load_words_t  o_words,
   output logic                  o_busy
);
   import mem_pkg::*;

   typedef enum logic [2:0] {
      S_IDLE,
      S_ISSUE,    // strobe held until memory goes busy
      S_WAIT,     // wait for memory busy to fall
      S_NEXT,     // set up the second word
      S_FINISH
   } seq_state_t;

   seq_state_t            r_state;
   logic                  r_stall;
   logic                  r_rd;       // read strobe
   logic                  r_wr;       // write strobe
   logic                  r_rd_op;    // access in flight is a load
   logic                  r_second;   // second word in flight
   logic                  r_two;
   logic [MEM_ADDR_W-1:0] r_idx;
   logic [3:0]            r_mask;
   logic [31:0]           r_wdata;
   logic [3:0]            r_mask1;
   logic [31:0]           r_wdata1;
   load_words_t           r_words;
   logic                  accept;
   logic                  word_done;

   assign accept    = (r_state == S_IDLE) && (i_rd_en || i_wr_en) && !i_mem_busy;
   assign word_done = (r_state == S_WAIT) && !i_mem_busy;
   assign o_busy    = r_stall | i_mem_busy;

   always_comb begin
      o_mem.rd    = r_rd;
      o_mem.wr    = r_wr;
      o_mem.idx   = r_idx;
      o_mem.mask  = r_mask;
      o_mem.wdata = r_wdata;
   end

   assign o_words = r_words;

   // FSM and strobes
   always_ff @(posedge clk) begin
      if (!rst_x) begin
         r_state  <= S_IDLE;
         r_stall  <= 1'b0;
         r_rd     <= 1'b0;
         r_wr     <= 1'b0;
         r_rd_op  <= 1'b0;
         r_second <= 1'b0;
      end else begin
         case (r_state)
            S_IDLE: begin
               if (accept) begin
                  r_stall  <= 1'b1;
                  r_rd_op  <= i_rd_en;   // read has priority
                  r_rd     <= i_rd_en;
                  r_wr     <= ~i_rd_en;
                  r_second <= 1'b0;
                  r_state  <= S_ISSUE;
               end
            end
            S_ISSUE: begin
               if (i_mem_busy) begin
                  r_rd    <= 1'b0;
                  r_wr    <= 1'b0;
                  r_state <= S_WAIT;
               end
            end
            S_WAIT: begin
               if (!i_mem_busy) begin
                  if (r_two && !r_second)
                     r_state <= S_NEXT;
                  else
                     r_state <= S_FINISH;
               end
            end
            S_NEXT: begin
               r_second <= 1'b1;
               r_rd     <= r_rd_op;
               r_wr     <= ~r_rd_op;
               r_state  <= S_ISSUE;
            end
            S_FINISH: begin
               r_stall <= 1'b0;
               r_state <= S_IDLE;
            end
            default: r_state <= S_IDLE;
         endcase
      end
   end

   // address, lanes and read words
   always_ff @(posedge clk) begin
      if (accept) begin
         r_idx    <= i_word_addr[MEM_ADDR_W-1:0];
         r_mask   <= i_plan.mask0;
         r_wdata  <= i_plan.wdata0;
         r_two    <= i_plan.two;
         r_mask1  <= i_plan.mask1;
         r_wdata1 <= i_plan.wdata1;
         if (i_rd_en) begin   // result holds until the next load
            r_words.offset <= i_plan.offset;
            r_words.ctrl   <= i_plan.ctrl;
         end
      end
      if (r_state == S_NEXT) begin
         r_idx   <= r_idx + 1'b1;   // next aligned word
         r_mask  <= r_mask1;
         r_wdata <= r_wdata1;
      end
      if (word_done && r_rd_op) begin
         if (r_second)
            r_words.hi <= i_mem_rdata;
         else
            r_words.lo <= i_mem_rdata;
      end
   end

endmodule

// ==== load_align.sv ====
// result block for loads
// shifts the captured word pair down by the byte offset and
// extends byte or halfword results, zero when ctrl[2] is set
`timescale 1ns/10ps

module load_align (
   input  mem_pkg::load_words_t i_words,
   output logic [31:0]          o_data
);
   import mem_pkg::*;

   logic [63:0] pair_sh;
   logic [31:0] val;
   logic        uns;

   assign pair_sh = {i_words.hi, i_words.lo} >> {i_words.offset, 3'b000};
   assign val     = pair_sh[31:0];
   assign uns     = i_words.ctrl[2];

   always_comb begin
      case (i_words.ctrl[1:0])
         SZ_BYTE: begin
            if (uns)
               o_data = {24'h0, val[7:0]};
            else
               o_data = {{24{val[7]}}, val[7:0]};
         end
         SZ_HALF: begin
            if (uns)
               o_data = {16'h0, val[15:0]};
            else
               o_data = {{16{val[15]}}, val[15:0]};
         end
         default: o_data = val;   // word, nothing to extend
      endcase
   end

endmodule

// ==== mem_pkg.sv ====
// shared definitions for the unaligned load/store unit
// size encodings, memory sizing and the structs passed between blocks
// imported by every module of the unit and by the testbench
package mem_pkg;

   // ctrl[1:0] is the access size, ctrl[2] marks an unsigned load
   localparam logic [1:0] SZ_BYTE = 2'd0;
   localparam logic [1:0] SZ_HALF = 2'd1;
   localparam logic [1:0] SZ_WORD = 2'd2;

   // behavioural word memory
   localparam int MEM_WORDS   = 1024;
   localparam int MEM_ADDR_W  = 10;   // word index width
   localparam int MEM_LATENCY = 3;    // busy cycles per word access
   localparam int LAT_CNT_W   = $clog2(MEM_LATENCY + 1);

   // one request from the core
   typedef struct packed {
      logic [31:0] addr;   // byte address
      logic [31:0] wdata;
      logic [2:0]  ctrl;
   } mem_req_t;

   // decoded access, one or two masked word accesses
   typedef struct packed {
      logic        two;      // crosses into the next word
      logic [3:0]  mask0;
      logic [3:0]  mask1;
      logic [31:0] wdata0;   // lanes of the first word
      logic [31:0] wdata1;   // spill-over lanes
      logic [1:0]  offset;
      logic [2:0]  ctrl;
   } access_plan_t;

   // sequencer to memory
   typedef struct packed {
      logic                  rd;
      logic                  wr;
      logic [MEM_ADDR_W-1:0] idx;
      logic [3:0]            mask;
      logic [31:0]           wdata;
   } mem_port_t;

   // captured read words for the result block
   typedef struct packed {
      logic [31:0] hi;
      logic [31:0] lo;
      logic [1:0]  offset;
      logic [2:0]  ctrl;
   } load_words_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and judge the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f unaligned_mem.f --top-module tb_unaligned_mem -o sim_unaligned_mem \
   && ./obj_dir/sim_unaligned_mem > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "All checks passed" sim.log 2>/dev/null \
   && echo "simulation PASSED" \
   || { echo "simulation FAILED"; exit 1; }

// ==== tb_unaligned_mem.sv ====
// testbench for the unaligned load/store unit
// keeps a byte model of memory, drives loads and stores on the falling edge
// and compares every load against a reference computed from the model
`timescale 1ns/10ps

module tb_unaligned_mem;
   import mem_pkg::*;

   localparam int REGION_WORDS = 64;   // words preloaded and exercised
   localparam int REGION_BYTES = REGION_WORDS * 4;
   localparam int BUSY_TIMEOUT = 100;  // cycles per wait

   logic        clk;
   logic        rst_x;
   logic        rd_en;
   logic        wr_en;
   logic [31:0] addr;
   logic [31:0] wdata;
   logic [2:0]  ctrl;
   logic [31:0] rdata;
   logic        busy;

   logic [7:0]  model [MEM_WORDS*4];
   logic [31:0] cmp_exp;
   logic [31:0] cmp_addr;
   logic [2:0]  cmp_ctrl;
   event        check_ev;
   int          checks = 0;
   int          errors = 0;
   int          test_errors = 0;
   int          test_num = 0;
   int          tests_failed = 0;
   string       test_name;

   unaligned_mem dut0 (
      .clk     (clk),
      .rst_x   (rst_x),
      .i_rd_en (rd_en),
      .i_wr_en (wr_en),
      .i_addr  (addr),
      .i_data  (wdata),
      .i_ctrl  (ctrl),
      .o_data  (rdata),
      .o_busy  (busy)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic int size_bytes(input logic [2:0] c);
      case (c[1:0])
         SZ_BYTE: return 1;
         SZ_HALF: return 2;
         default: return 4;
      endcase
   endfunction

   // expected load value straight from the byte model
   function automatic logic [31:0] ref_load(input logic [31:0] a, input logic [2:0] c);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < size_bytes(c); i++)
         v[8*i +: 8] = model[a + i];
      if (!c[2] && c[1:0] == SZ_BYTE)
         v = {{24{v[7]}}, v[7:0]};
      else if (!c[2] && c[1:0] == SZ_HALF)
         v = {{16{v[15]}}, v[15:0]};
      return v;
   endfunction

   // compare process woken once per finished load
   initial begin
      forever begin
         @(check_ev);
         checks++;
         assert (rdata === cmp_exp) else begin
            errors++;
            test_errors++;
            $display("CHECK FAILED at %0t: load addr %h ctrl %b got %h expected %h",
                     $time, cmp_addr, cmp_ctrl, rdata, cmp_exp);
         end
      end
   end

   task automatic wait_busy_level(input logic level);
      int cnt;
      cnt = 0;
      while (busy !== level && cnt < BUSY_TIMEOUT) begin
         @(negedge clk);
         cnt++;
      end
      if (busy !== level) begin
         $display("timeout: o_busy did not reach %0b within %0d cycles at %0t",
                  level, BUSY_TIMEOUT, $time);
         $display("Checks failed");
         $finish;
      end
   endtask

   task automatic drive_req(input logic rd, input logic [31:0] a, input logic [31:0] d,
                            input logic [2:0] c);
      @(negedge clk);
      rd_en = rd;
      wr_en = ~rd;
      addr  = a;
      wdata = d;
      ctrl  = c;
   endtask

   task automatic complete_req();
      wait_busy_level(1'b1);   // accepted
      rd_en = 1'b0;
      wr_en = 1'b0;
      wait_busy_level(1'b0);
   endtask

   task automatic check_load(input logic [31:0] a, input logic [2:0] c);
      cmp_addr = a;
      cmp_ctrl = c;
      cmp_exp  = ref_load(a, c);
      -> check_ev;
   endtask

   task automatic store(input logic [31:0] a, input logic [31:0] d, input logic [2:0] c);
      drive_req(1'b0, a, d, c);
      complete_req();
      for (int i = 0; i < size_bytes(c); i++)
         model[a + i] = d[8*i +: 8];
   endtask

   task automatic load(input logic [31:0] a, input logic [2:0] c);
      drive_req(1'b1, a, 32'h0, c);
      complete_req();
      check_load(a, c);
   endtask

   task automatic start_test(input string name);
      test_num++;
      test_name   = name;
      test_errors = 0;
   endtask

   task automatic end_test();
      @(negedge clk);   // let the last compare land
      if (test_errors != 0)
         tests_failed++;
      $display("test %0d %s: %s (%0d errors)", test_num, test_name,
               (test_errors == 0) ? "ok" : "FAILED", test_errors);
   endtask

   initial begin
      logic [31:0] a;
      logic [2:0]  c;
      rst_x = 1'b0;
      rd_en = 1'b0;
      wr_en = 1'b0;
      addr  = '0;
      wdata = '0;
      ctrl  = '0;
      void'($urandom(84));
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_x = 1'b1;

      start_test("reset and aligned word");
      checks++;
      assert (busy === 1'b0) else begin
         errors++;
         test_errors++;
         $display("CHECK FAILED at %0t: o_busy high after reset", $time);
      end
      store(32'h10, 32'h1234_5678, {1'b0, SZ_WORD});
      load(32'h10, {1'b0, SZ_WORD});
      end_test();

      // known contents so unaligned loads never touch unwritten words
      for (int w = 0; w < REGION_WORDS; w++)
         store(32'(w * 4), (32'(w) + 1) * 32'h9e37_79b1 ^ 32'h5a5a_0000, {1'b0, SZ_WORD});

      start_test("byte and halfword loads");
      store(32'h20, 32'h80ff_7f01, {1'b0, SZ_WORD});
      store(32'h24, 32'hc0a0_5590, {1'b0, SZ_WORD});
      for (int off = 0; off < 4; off++) begin
         load(32'h20 + off, {1'b0, SZ_BYTE});
         load(32'h20 + off, {1'b1, SZ_BYTE});
         load(32'h20 + off, {1'b0, SZ_HALF});
         load(32'h20 + off, {1'b1, SZ_HALF});
      end
      end_test();

      start_test("unaligned words");
      for (int k = 1; k < 4; k++) begin
         a = 32'h40 + 16 * k + k;
         store(a, 32'hf00d_0000 | 32'(k * 32'h1111), {1'b0, SZ_WORD});
         load(a, {1'b0, SZ_WORD});
         load(a & ~32'h3, {1'b0, SZ_WORD});         // low word keeps its other lanes
         load((a & ~32'h3) + 4, {1'b0, SZ_WORD});   // high word
      end
      end_test();

      start_test("halfword at offset 3");
      store(32'h93, 32'h0000_a5c3, {1'b0, SZ_HALF});
      load(32'h93, {1'b0, SZ_HALF});
      load(32'h93, {1'b1, SZ_HALF});
      load(32'h90, {1'b0, SZ_WORD});
      load(32'h94, {1'b0, SZ_WORD});
      end_test();

      start_test("random mix");
      for (int n = 0; n < 200; n++) begin
         a = 32'($urandom_range(0, REGION_BYTES - 5));
         c = {1'($urandom % 2), 2'($urandom % 3)};
         if ($urandom % 2)
            store(a, $urandom, c);
         else
            load(a, c);
      end
      end_test();

      start_test("back-pressure");
      drive_req(1'b1, 32'h41, 32'h0, {1'b0, SZ_WORD});   // two-word read
      wait_busy_level(1'b1);
      rd_en = 1'b0;
      @(negedge clk);
      wr_en = 1'b1;   // single cycle pulse to be dropped
      addr  = 32'h80;
      wdata = 32'hdead_beef;
      ctrl  = {1'b0, SZ_WORD};
      @(negedge clk);
      wr_en = 1'b0;
      wait_busy_level(1'b0);
      check_load(32'h41, {1'b0, SZ_WORD});
      load(32'h80, {1'b0, SZ_WORD});
      drive_req(1'b1, 32'h45, 32'h0, {1'b0, SZ_HALF});
      wait_busy_level(1'b1);
      rd_en = 1'b0;
      wr_en = 1'b1;   // held until the read is done
      addr  = 32'h86;
      wdata = 32'h0000_3c7e;
      ctrl  = {1'b0, SZ_HALF};
      wait_busy_level(1'b0);
      check_load(32'h45, {1'b0, SZ_HALF});
      wait_busy_level(1'b1);
      wr_en = 1'b0;
      wait_busy_level(1'b0);
      model[32'h86] = 8'h7e;
      model[32'h87] = 8'h3c;
      load(32'h86, {1'b1, SZ_HALF});
      load(32'h84, {1'b0, SZ_WORD});
      end_test();

      @(negedge clk);
      $display("tests run %0d, failed %0d; checks run %0d, failed %0d",
               test_num, tests_failed, checks, errors);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

// ==== unaligned_mem.f ====
mem_pkg.sv
access_decode.sv
access_sequencer.sv
load_align.sv
word_mem.sv
unaligned_mem.sv
tb_unaligned_mem.sv

// ==== unaligned_mem.sv ====
// top level of the unaligned load/store unit
// core side takes level enables while o_busy is low;
// decode, sequencer, load result and word memory are wired here
`timescale 1ns/10ps

module unaligned_mem (
   input  logic        clk,
   input  logic        rst_x,
   input  logic        i_rd_en,
   input  logic        i_wr_en,
   input  logic [31:0] i_addr,
   input  logic [31:0] i_data,
   input  logic [2:0]  i_ctrl,
   output logic [31:0] o_data,
   output logic        o_busy
);
   import mem_pkg::*;

   mem_req_t     w_req;
   access_plan_t w_plan;
   mem_port_t    w_port;
   load_words_t  w_words;
   logic [31:0]  w_mem_rdata;
   logic         w_mem_busy;

   assign w_req = '{addr: i_addr, wdata: i_data, ctrl: i_ctrl};

   access_decode u_decode (
      .i_req  (w_req),
      .o_plan (w_plan)
   );

   access_sequencer u_seq (
      .clk         (clk),
      .rst_x       (rst_x),
      .i_rd_en     (i_rd_en),
      .i_wr_en     (i_wr_en),
      .i_plan      (w_plan),
      .i_word_addr (i_addr[31:2]),
      .i_mem_busy  (w_mem_busy),
      .i_mem_rdata (w_mem_rdata),
      .o_mem       (w_port),
      .o_words     (w_words),
      .o_busy      (o_busy)
   );

   load_align u_align (
      .i_words (w_words),
      .o_data  (o_data)
   );

   word_mem u_mem (
      .clk     (clk),
      .rst_x   (rst_x),
      .i_port  (w_port),
      .o_rdata (w_mem_rdata),
      .o_busy  (w_mem_busy)
   );

endmodule

// ==== word_mem.sv ====
// behavioural word memory behind the load/store unit
// one read or masked write per accepted strobe, then busy
// for a fixed number of cycles; read data is valid once busy falls
`timescale 1ns/10ps

module word_mem (
   input  logic               clk,
   input  logic               rst_x,
   input  mem_pkg::mem_port_t i_port,
   output logic [31:0]        o_rdata,
   output logic               o_busy
);
   import mem_pkg::*;

   logic [31:0]          mem [MEM_WORDS];
   logic [31:0]          r_rdata;
   logic                 r_busy;
   logic [LAT_CNT_W-1:0] r_cnt;     // busy cycles left
   logic                 accept;

   assign accept  = (i_port.rd | i_port.wr) & ~r_busy;
   assign o_rdata = r_rdata;
   assign o_busy  = r_busy;

   // busy counter
   always_ff @(posedge clk) begin
      if (!rst_x) begin
         r_busy <= 1'b0;
         r_cnt  <= '0;
      end else if (accept) begin
         r_busy <= 1'b1;
         r_cnt  <= LAT_CNT_W'(MEM_LATENCY - 1);
      end else if (r_busy) begin
         if (r_cnt == '0)
            r_busy <= 1'b0;
         else
            r_cnt <= r_cnt - 1'b1;
      end
   end

   // storage, byte lanes written under the mask
   always_ff @(posedge clk) begin
      if (accept && i_port.wr) begin
         for (int lane = 0; lane < 4; lane++) begin
            if (i_port.mask[lane])
               mem[i_port.idx][8*lane +: 8] <= i_port.wdata[8*lane +: 8];
         end
      end
      if (accept && i_port.rd)
         r_rdata <= mem[i_port.idx];
   end

endmodule
